/* include/cordic_consts.svh */
/*
 * Fixed-point constants of the CORDIC unit.
 * Words are signed Q2.30 with 30 fraction bits, so values lie in [-2, 2).
 * Only the 32-bit word with 16 iterations is supported.
 * The arctangent values are atan(2^-i) scaled by 2^30 and rounded to nearest.
 */
`ifndef CORDIC_CONSTS_SVH
`define CORDIC_CONSTS_SVH

// ----------------------------------------
// Word format and iteration count
// ----------------------------------------
`define CORDIC_W            32              // Data word width.
`define CORDIC_FRAC         30              // Fraction bits of a word.
`define CORDIC_ITER_BITS    4               // Width of the iteration index.
`define CORDIC_ITERS        16              // Iterations per request.

// Initial X, the inverse CORDIC gain 0.607252935.
`define CORDIC_X0           32'h26DD3B6A

// ----------------------------------------
// Arctangent table, atan(2^-i)
// ----------------------------------------
`define CORDIC_ATAN_0       32'h3243F6A9    // pi/4.
`define CORDIC_ATAN_1       32'h1DAC6705
`define CORDIC_ATAN_2       32'h0FADBAFD
`define CORDIC_ATAN_3       32'h07F56EA7
`define CORDIC_ATAN_4       32'h03FEAB77
`define CORDIC_ATAN_5       32'h01FFD55C
`define CORDIC_ATAN_6       32'h00FFFAAB
`define CORDIC_ATAN_7       32'h007FFF55
`define CORDIC_ATAN_8       32'h003FFFEB
`define CORDIC_ATAN_9       32'h001FFFFD
`define CORDIC_ATAN_10      32'h00100000    // From here atan(x) rounds to x.
`define CORDIC_ATAN_11      32'h00080000
`define CORDIC_ATAN_12      32'h00040000
`define CORDIC_ATAN_13      32'h00020000
`define CORDIC_ATAN_14      32'h00010000
`define CORDIC_ATAN_15      32'h00008000

`endif

/* source/cordic_data_pkg.sv */
/*
 * Types of the CORDIC data path.
 * Words are two's-complement Q2.30 and the width comes from the constants header.
 * Region bit 0 negates a cosine result and bit 1 negates a sine result.
 */
`include "cordic_consts.svh"

package cordic_data_pkg;

    typedef logic signed [`CORDIC_W-1:0] word_t;     // Signed fixed-point word.

    typedef enum logic
    {
        op_cos = 1'b0,                                // Result taken from X.
        op_sin = 1'b1                                 // Result taken from Y.
    } op_e;

    typedef enum logic [1:0]
    {
        region_direct   = 2'b00,                      // No correction.
        region_neg_cos  = 2'b01,                      // Negate a cosine.
        region_neg_sin  = 2'b10,                      // Negate a sine.
        region_neg_both = 2'b11                       // Negate either result.
    } region_e;

endpackage

/* source/cordic_ctrl_pkg.sv */
/*
 * Types of the CORDIC sequencer.
 * The variable code 2'b11 is never produced and is treated as Z where decoded.
 */
`include "cordic_consts.svh"

package cordic_ctrl_pkg;

    typedef enum logic [2:0]
    {
        st_idle   = 3'd0,                             // Waiting for a start.
        st_load   = 3'd1,                             // Capture the request.
        st_latch  = 3'd2,                             // Load working registers.
        st_update = 3'd3,                             // One variable per cycle.
        st_output = 3'd4,                             // Register the result.
        st_ready  = 3'd5                              // Hold until acknowledge.
    } state_e;

    typedef enum logic [1:0]
    {
        var_x = 2'd0,
        var_y = 2'd1,
        var_z = 2'd2
    } var_e;

    typedef logic [`CORDIC_ITER_BITS-1:0] iter_t;    // Iteration index and shift.

endpackage

/* source/cordic_atan_rom.sv */
/*
 * Arctangent lookup, atan(2^-iter) in Q2.30.
 * Purely combinational, the address is the iteration index.
 */
`include "cordic_consts.svh"

module cordic_atan_rom
(
    input  cordic_ctrl_pkg::iter_t iter,             // Table address.
    output cordic_data_pkg::word_t atan              // Angle step for this iteration.
);

    always_comb
    begin
        case (iter)
            4'd0:    atan = `CORDIC_ATAN_0;
            4'd1:    atan = `CORDIC_ATAN_1;
            4'd2:    atan = `CORDIC_ATAN_2;
            4'd3:    atan = `CORDIC_ATAN_3;
            4'd4:    atan = `CORDIC_ATAN_4;
            4'd5:    atan = `CORDIC_ATAN_5;
            4'd6:    atan = `CORDIC_ATAN_6;
            4'd7:    atan = `CORDIC_ATAN_7;
            4'd8:    atan = `CORDIC_ATAN_8;
            4'd9:    atan = `CORDIC_ATAN_9;
            4'd10:   atan = `CORDIC_ATAN_10;
            4'd11:   atan = `CORDIC_ATAN_11;
            4'd12:   atan = `CORDIC_ATAN_12;
            4'd13:   atan = `CORDIC_ATAN_13;
            4'd14:   atan = `CORDIC_ATAN_14;
            default: atan = `CORDIC_ATAN_15;         // Index 15.
        endcase
    end

endmodule

/* source/cordic_fsm.sv */
/*
 * Sequencer of the iterative CORDIC unit.
 * A start is sampled only in idle, starts while busy are ignored.
 * Each iteration is one latch cycle followed by X, Y and Z update cycles.
 * ready_cordic is a level and holds until ack_cordic is seen high.
 */
`include "cordic_consts.svh"

module cordic_fsm
(
    input  logic                   clk,              // System clock.
    input  logic                   arst_n,           // Asynchronous reset, active low.
    input  logic                   beg_fsm_cordic,   // Start strobe.
    input  logic                   ack_cordic,       // Result taken.
    output logic                   ready_cordic,     // Result valid, held.
    output logic                   load_inputs,      // Capture request inputs.
    output logic                   latch_work,       // Load working registers.
    output logic                   first_iter,       // Pick the initial values.
    output logic                   upd_en,           // Write a result register.
    output cordic_ctrl_pkg::var_e  upd_var,          // Variable under update.
    output cordic_ctrl_pkg::iter_t iter,             // Shift amount and table address.
    output logic                   out_en            // Register the final output.
);

    cordic_ctrl_pkg::state_e state_q;                // Current state.
    cordic_ctrl_pkg::state_e state_d;                // Next state.
    cordic_ctrl_pkg::iter_t  iter_q;                 // Iteration counter.
    cordic_ctrl_pkg::var_e   var_q;                  // Variable counter.
    logic                    last_var;               // Z is being updated.
    logic                    last_iter;              // Final iteration.

    assign last_var  = (var_q == cordic_ctrl_pkg::var_z);
    assign last_iter = (iter_q == cordic_ctrl_pkg::iter_t'(`CORDIC_ITERS - 1));

    // ----------------------------------------
    // State register and next state
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            state_q <= cordic_ctrl_pkg::st_idle;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        state_d = state_q;                           // Hold by default.
        case (state_q)
            cordic_ctrl_pkg::st_idle:
                if (beg_fsm_cordic)
                    state_d = cordic_ctrl_pkg::st_load;
            cordic_ctrl_pkg::st_load:
                state_d = cordic_ctrl_pkg::st_latch;
            cordic_ctrl_pkg::st_latch:
                state_d = cordic_ctrl_pkg::st_update;
            cordic_ctrl_pkg::st_update:
                if (last_var)
                    state_d = last_iter ? cordic_ctrl_pkg::st_output
                                        : cordic_ctrl_pkg::st_latch;
            cordic_ctrl_pkg::st_output:
                state_d = cordic_ctrl_pkg::st_ready;
            cordic_ctrl_pkg::st_ready:
                if (ack_cordic)
                    state_d = cordic_ctrl_pkg::st_idle;
            default:
                state_d = cordic_ctrl_pkg::st_idle;  // Unused codes recover to idle.
        endcase
    end

    // ----------------------------------------
    // Iteration and variable counters
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            iter_q <= '0;
            var_q  <= cordic_ctrl_pkg::var_x;
        end
        else if (state_q == cordic_ctrl_pkg::st_load)
        begin
            iter_q <= '0;                            // Fresh count per request.
            var_q  <= cordic_ctrl_pkg::var_x;
        end
        else if (state_q == cordic_ctrl_pkg::st_update)
        begin
            if (last_var)
            begin
                var_q  <= cordic_ctrl_pkg::var_x;    // Wrap to X.
                iter_q <= iter_q + 1'b1;             // Next iteration.
            end
            else
                var_q <= cordic_ctrl_pkg::var_e'(var_q + 2'd1);
        end
    end

    // Moore decodes of the state.
    assign ready_cordic = (state_q == cordic_ctrl_pkg::st_ready);
    assign load_inputs  = (state_q == cordic_ctrl_pkg::st_load);
    assign latch_work   = (state_q == cordic_ctrl_pkg::st_latch);
    assign first_iter   = latch_work && (iter_q == '0);  // Only iteration 0 starts from X0/Y0.
    assign upd_en       = (state_q == cordic_ctrl_pkg::st_update);
    assign upd_var      = var_q;
    assign iter         = iter_q;
    assign out_en       = (state_q == cordic_ctrl_pkg::st_output);

endmodule

/* source/cordic_datapath.sv */
/*
 * CORDIC rotation data path with one shared adder/subtractor.
 * X, Y and Z are updated one per cycle from working copies latched at the
 * start of each iteration, so Y sees the old X as the algorithm requires.
 * Shifts are arithmetic, low bits are truncated.
 */
`include "cordic_consts.svh"

module cordic_datapath
(
    input  logic                     clk,            // System clock.
    input  logic                     arst_n,         // Asynchronous reset, active low.
    input  cordic_data_pkg::op_e     operation,      // Sine or cosine.
    input  cordic_data_pkg::region_e shift_region_flag,
    input  cordic_data_pkg::word_t   data_in,        // Angle in Q2.30.
    input  logic                     load_inputs,
    input  logic                     latch_work,
    input  logic                     first_iter,
    input  logic                     upd_en,
    input  cordic_ctrl_pkg::var_e    upd_var,
    input  cordic_ctrl_pkg::iter_t   iter,
    output cordic_data_pkg::word_t   x_res,          // Latest X result.
    output cordic_data_pkg::word_t   y_res,          // Latest Y result.
    output cordic_data_pkg::op_e     op_q,           // Captured operation.
    output cordic_data_pkg::region_e region_q        // Captured region flag.
);

    cordic_data_pkg::word_t z_in;                    // Captured angle.
    cordic_data_pkg::word_t z_res;                   // Latest Z result.
    cordic_data_pkg::word_t x_init;
    cordic_data_pkg::word_t y_init;
    cordic_data_pkg::word_t z_init;
    cordic_data_pkg::word_t x_w;                     // Working copies.
    cordic_data_pkg::word_t y_w;
    cordic_data_pkg::word_t z_w;
    cordic_data_pkg::word_t x_sh;
    cordic_data_pkg::word_t y_sh;
    cordic_data_pkg::word_t atan;
    cordic_data_pkg::word_t opa;                     // Adder operand A.
    cordic_data_pkg::word_t opb;                     // Adder operand B.
    cordic_data_pkg::word_t sum;
    logic                   sign_q;                  // Z was negative, d = -1.
    logic                   sub_op;

    // ----------------------------------------
    // Input capture
    // ----------------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            op_q     <= cordic_data_pkg::op_cos;
            region_q <= cordic_data_pkg::region_direct;
        end
        else if (load_inputs)
        begin
            op_q     <= operation;
            region_q <= shift_region_flag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_inputs)
            z_in <= data_in;
    end

    // ----------------------------------------
    // Working registers and direction
    // ----------------------------------------
    assign x_init = first_iter ? cordic_data_pkg::word_t'(`CORDIC_X0) : x_res;
    assign y_init = first_iter ? '0 : y_res;        // Y starts at zero.
    assign z_init = first_iter ? z_in : z_res;

    always_ff @(posedge clk)
    begin
        if (latch_work)
        begin
            x_w <= x_init;
            y_w <= y_init;
            z_w <= z_init;
        end
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            sign_q <= 1'b0;
        else if (latch_work)
            sign_q <= z_init[`CORDIC_W-1];           // Sign of the Z being latched.
    end

    assign x_sh = x_w >>> iter;
    assign y_sh = y_w >>> iter;

    cordic_atan_rom u_atan_rom
    (
        .iter (iter),
        .atan (atan)
    );

    // ----------------------------------------
    // Shared add/subtract
    // ----------------------------------------
    always_comb
    begin
        case (upd_var)
            cordic_ctrl_pkg::var_x:
            begin
                opa = x_w;
                opb = y_sh;
            end
            cordic_ctrl_pkg::var_y:
            begin
                opa = y_w;
                opb = x_sh;
            end
            default:
            begin
                opa = z_w;                           // Z step from the table.
                opb = atan;
            end
        endcase
    end

    // Y adds for d = +1, X and Z subtract.
    assign sub_op = (upd_var == cordic_ctrl_pkg::var_y) ? sign_q : !sign_q;
    assign sum    = sub_op ? (opa - opb) : (opa + opb);

    always_ff @(posedge clk)
    begin
        if (upd_en)
        begin
            case (upd_var)
                cordic_ctrl_pkg::var_x: x_res <= sum;
                cordic_ctrl_pkg::var_y: y_res <= sum;
                default:                z_res <= sum;
            endcase
        end
    end

endmodule

/* source/cordic_output_stage.sv */
/*
 * Output selection and region sign correction.
 * Sine takes Y and cosine takes X. The region bit of the chosen operation
 * negates the value before it is registered.
 */
module cordic_output_stage
(
    input  logic                     clk,            // System clock.
    input  logic                     arst_n,         // Asynchronous reset, active low.
    input  logic                     out_en,         // Register the result.
    input  cordic_data_pkg::word_t   x_res,          // Cosine candidate.
    input  cordic_data_pkg::word_t   y_res,          // Sine candidate.
    input  cordic_data_pkg::op_e     op_q,
    input  cordic_data_pkg::region_e region_q,
    output cordic_data_pkg::word_t   data_output     // Final result, held.
);

    cordic_data_pkg::word_t sel_val;
    cordic_data_pkg::word_t fixed_val;
    logic                   negate;

    assign sel_val   = (op_q == cordic_data_pkg::op_sin) ? y_res : x_res;
    assign negate    = (op_q == cordic_data_pkg::op_sin) ? region_q[1] : region_q[0];
    assign fixed_val = negate ? -sel_val : sel_val;  // Two's-complement negate.

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            data_output <= '0;
        else if (out_en)
            data_output <= fixed_val;
    end

endmodule

/* source/cordic_top.sv */
/*
 * Iterative CORDIC sine/cosine unit in rotation mode.
 * The angle must lie within -pi/2 to +pi/2 in Q2.30.
 * One request at a time, the result is valid 67 edges after the start is sampled.
 */
module cordic_top
(
    input  logic                     clk,                // System clock.
    input  logic                     arst_n,             // Asynchronous reset, active low.
    input  logic                     beg_fsm_cordic,     // Start strobe.
    input  logic                     ack_cordic,         // Result taken.
    input  cordic_data_pkg::op_e     operation,          // Sine or cosine.
    input  cordic_data_pkg::region_e shift_region_flag,  // Sign correction.
    input  cordic_data_pkg::word_t   data_in,            // Angle.
    output logic                     ready_cordic,       // Result valid.
    output cordic_data_pkg::word_t   data_output         // Result.
);

    logic                     load_inputs;
    logic                     latch_work;
    logic                     first_iter;
    logic                     upd_en;
    logic                     out_en;
    cordic_ctrl_pkg::var_e    upd_var;
    cordic_ctrl_pkg::iter_t   iter;
    cordic_data_pkg::word_t   x_res;
    cordic_data_pkg::word_t   y_res;
    cordic_data_pkg::op_e     op_q;
    cordic_data_pkg::region_e region_q;

    cordic_fsm u_fsm
    (
        .clk            (clk),
        .arst_n         (arst_n),
        .beg_fsm_cordic (beg_fsm_cordic),
        .ack_cordic     (ack_cordic),
        .ready_cordic   (ready_cordic),
        .load_inputs    (load_inputs),
        .latch_work     (latch_work),
        .first_iter     (first_iter),
        .upd_en         (upd_en),
        .upd_var        (upd_var),
        .iter           (iter),
        .out_en         (out_en)
    );

    cordic_datapath u_datapath
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .operation         (operation),
        .shift_region_flag (shift_region_flag),
        .data_in           (data_in),
        .load_inputs       (load_inputs),
        .latch_work        (latch_work),
        .first_iter        (first_iter),
        .upd_en            (upd_en),
        .upd_var           (upd_var),
        .iter              (iter),
        .x_res             (x_res),
        .y_res             (y_res),
        .op_q              (op_q),
        .region_q          (region_q)
    );

    cordic_output_stage u_output_stage
    (
        .clk         (clk),
        .arst_n      (arst_n),
        .out_en      (out_en),
        .x_res       (x_res),
        .y_res       (y_res),
        .op_q        (op_q),
        .region_q    (region_q),
        .data_output (data_output)
    );

endmodule

/* verification/cordic_props.sv */
/*
 * Protocol assertions for the CORDIC top level, attached with bind.
 * Latency is counted from the load cycle that follows an accepted start.
 */
module cordic_props
(
    input logic                   clk,               // System clock.
    input logic                   arst_n,            // Asynchronous reset, active low.
    input logic                   ack_cordic,        // Result taken.
    input logic                   ready_cordic,      // Result valid.
    input logic                   load_inputs,       // Start accepted one edge earlier.
    input cordic_data_pkg::word_t data_output        // Result.
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned fail_cnt = 0;                       // Failed assertions so far.

    // ----------------------------------------
    // Ready / acknowledge protocol
    // ----------------------------------------
    ready_held: assert property (@(posedge clk) disable iff (!arst_n)
        ready_cordic && !ack_cordic |=> ready_cordic)
    else
    begin
        fail_cnt++;
        $error("ready_cordic fell before ack_cordic was seen");
    end

    data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        ready_cordic && !ack_cordic |=> $stable(data_output))
    else
    begin
        fail_cnt++;
        $error("data_output changed while ready_cordic was held");
    end

    // Start on edge 0, load on edge 1, ready seen 67 edges after the start.
    ready_latency: assert property (@(posedge clk) disable iff (!arst_n)
        load_inputs |-> ##66 $rose(ready_cordic))
    else
    begin
        fail_cnt++;
        $error("ready_cordic did not rise 67 edges after the start");
    end

endmodule

bind cordic_top cordic_props u_props
(
    .clk          (clk),
    .arst_n       (arst_n),
    .ack_cordic   (ack_cordic),
    .ready_cordic (ready_cordic),
    .load_inputs  (load_inputs),
    .data_output  (data_output)
);

/* verification/cordic_tb.sv */
/*
 * Directed testbench for the CORDIC sine/cosine unit.
 * Expected values come from $sin and $cos, a result passes within 2^-13.
 * Angles stay within -pi/2 to +pi/2, the range the unit accepts.
 * Failed assertions of the bound protocol checker count as errors.
 */
module cordic_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam real PI            = 3.14159265358979323846;
    localparam real SCALE         = 1073741824.0;    // One in Q2.30.
    localparam int  READY_TIMEOUT = 100;             // Wait limit in cycles above the 67 needed.
    localparam int  N_ANGLES      = 12;
    localparam cordic_data_pkg::word_t TOL = 32'sd131072;  // 2^-13 in Q2.30.

    logic                     clk;
    logic                     arst_n;
    logic                     beg_fsm_cordic;
    logic                     ack_cordic;
    cordic_data_pkg::op_e     operation;
    cordic_data_pkg::region_e shift_region_flag;
    cordic_data_pkg::word_t   data_in;
    logic                     ready_cordic;
    cordic_data_pkg::word_t   data_output;

    int unsigned              n_tests;
    int unsigned              n_failed;
    int unsigned              n_checks;
    int unsigned              n_errors;
    logic [31:0]              rng_state;             // Xorshift state.
    cordic_data_pkg::word_t   angles [N_ANGLES];     // Shared by the sine and cosine tests.

    cordic_top DUT
    (
        .clk               (clk),
        .arst_n            (arst_n),
        .beg_fsm_cordic    (beg_fsm_cordic),
        .ack_cordic        (ack_cordic),
        .operation         (operation),
        .shift_region_flag (shift_region_flag),
        .data_in           (data_in),
        .ready_cordic      (ready_cordic),
        .data_output       (data_output)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period.
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic cordic_data_pkg::word_t to_fixed(input real v);
        return cordic_data_pkg::word_t'($rtoi(v * SCALE));
    endfunction

    function automatic real to_real(input cordic_data_pkg::word_t w);
        return $itor(w) / SCALE;
    endfunction

    task automatic check_word(input string name, input cordic_data_pkg::word_t expected,
                              input cordic_data_pkg::word_t actual,
                              input cordic_data_pkg::word_t tol);
        longint diff;
        diff = longint'(actual) - longint'(expected);
        n_checks++;
        if ($isunknown(actual) || diff > longint'(tol) || diff < -longint'(tol))
        begin
            n_errors++;
            $display("** Error %s: expected %h (%f), actual %h (%f)", name,
                     expected, to_real(expected), actual, to_real(actual));
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic start_request(input cordic_data_pkg::op_e op,
                                 input cordic_data_pkg::region_e region,
                                 input cordic_data_pkg::word_t angle);
        @(posedge clk);
        beg_fsm_cordic    <= 1'b1;
        operation         <= op;
        shift_region_flag <= region;
        data_in           <= angle;
        @(posedge clk);
        beg_fsm_cordic    <= 1'b0;                   // One-cycle strobe.
    endtask

    task automatic wait_ready(input string name, output bit ok);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (ready_cordic !== 1'b1 && cycles < READY_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        ok = (ready_cordic === 1'b1);
        if (!ok)
        begin
            n_errors++;
            $display("Timeout in %s: ready_cordic did not rise within %0d cycles",
                     name, READY_TIMEOUT);
        end
    endtask

    task automatic send_ack(input string name);
        int cycles;
        cycles = 0;
        @(posedge clk);
        ack_cordic <= 1'b1;
        @(negedge clk);
        while (ready_cordic !== 1'b0 && cycles < READY_TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (ready_cordic !== 1'b0)
        begin
            n_errors++;
            $display("Timeout in %s: ready_cordic stayed high after ack_cordic", name);
        end
        @(posedge clk);
        ack_cordic <= 1'b0;
    endtask

    task automatic run_and_compare(input string name, input cordic_data_pkg::op_e op,
                                   input cordic_data_pkg::region_e region,
                                   input cordic_data_pkg::word_t angle, input real expected);
        bit ok;
        start_request(op, region, angle);
        wait_ready(name, ok);
        if (ok)
            check_word(name, to_fixed(expected), data_output, TOL);
        send_ack(name);
    endtask

    task automatic report_test(input string name, input int unsigned errs_before);
        n_tests++;
        if (n_errors == errs_before)
            $display("Test %s: ok", name);
        else
        begin
            n_failed++;
            $display("Test %s: %0d errors", name, n_errors - errs_before);
        end
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic reset_values();
        int unsigned errs_before;
        errs_before = n_errors;
        @(negedge clk);
        check_bit("reset_values", 1'b0, ready_cordic);
        check_word("reset_values", '0, data_output, '0);
        report_test("reset_values", errs_before);
    endtask

    task automatic sine_direct();
        int unsigned errs_before;
        int          i;
        errs_before = n_errors;
        for (i = 0; i < N_ANGLES; i++)
            run_and_compare("sine_direct", cordic_data_pkg::op_sin,
                            cordic_data_pkg::region_direct, angles[i],
                            $sin(to_real(angles[i])));
        report_test("sine_direct", errs_before);
    endtask

    task automatic cosine_direct();
        int unsigned errs_before;
        int          i;
        errs_before = n_errors;
        for (i = 0; i < N_ANGLES; i++)
            run_and_compare("cosine_direct", cordic_data_pkg::op_cos,
                            cordic_data_pkg::region_direct, angles[i],
                            $cos(to_real(angles[i])));
        report_test("cosine_direct", errs_before);
    endtask

    task automatic region_flags();
        int unsigned errs_before;
        int          k;
        real         s;
        real         c;
        errs_before = n_errors;
        for (k = 1; k <= 3; k += 2)                  // pi/6, then -pi/3.
        begin
            s = $sin(to_real(angles[k]));
            c = $cos(to_real(angles[k]));
            run_and_compare("region_flags", cordic_data_pkg::op_sin,
                            cordic_data_pkg::region_neg_sin, angles[k], -s);
            run_and_compare("region_flags", cordic_data_pkg::op_cos,
                            cordic_data_pkg::region_neg_sin, angles[k], c);
            run_and_compare("region_flags", cordic_data_pkg::op_sin,
                            cordic_data_pkg::region_neg_cos, angles[k], s);
            run_and_compare("region_flags", cordic_data_pkg::op_cos,
                            cordic_data_pkg::region_neg_cos, angles[k], -c);
            run_and_compare("region_flags", cordic_data_pkg::op_sin,
                            cordic_data_pkg::region_neg_both, angles[k], -s);
            run_and_compare("region_flags", cordic_data_pkg::op_cos,
                            cordic_data_pkg::region_neg_both, angles[k], -c);
        end
        report_test("region_flags", errs_before);
    endtask

    task automatic back_pressure();
        int unsigned            errs_before;
        int                     i;
        bit                     ok;
        cordic_data_pkg::word_t held;
        errs_before = n_errors;
        start_request(cordic_data_pkg::op_sin, cordic_data_pkg::region_direct, angles[2]);
        wait_ready("back_pressure", ok);
        held = data_output;
        check_word("back_pressure", to_fixed($sin(to_real(angles[2]))), held, TOL);
        for (i = 0; i < 20; i++)                     // Acknowledge held low.
        begin
            @(negedge clk);
            check_bit("back_pressure", 1'b1, ready_cordic);
            check_word("back_pressure", held, data_output, '0);
        end
        send_ack("back_pressure");
        @(negedge clk);
        check_bit("back_pressure", 1'b0, ready_cordic);
        run_and_compare("back_pressure", cordic_data_pkg::op_cos,
                        cordic_data_pkg::region_direct, angles[1], $cos(to_real(angles[1])));
        report_test("back_pressure", errs_before);
    endtask

    task automatic start_while_busy();
        int unsigned errs_before;
        int          i;
        bit          ok;
        errs_before = n_errors;
        start_request(cordic_data_pkg::op_sin, cordic_data_pkg::region_direct, angles[4]);
        repeat (10) @(posedge clk);
        // Second strobe lands mid-run with other inputs.
        start_request(cordic_data_pkg::op_cos, cordic_data_pkg::region_neg_both, angles[5]);
        wait_ready("start_while_busy", ok);
        if (ok)
            check_word("start_while_busy", to_fixed($sin(to_real(angles[4]))),
                       data_output, TOL);
        send_ack("start_while_busy");
        for (i = 0; i < 80; i++)                     // No second run may follow.
        begin
            @(negedge clk);
            check_bit("start_while_busy", 1'b0, ready_cordic);
        end
        report_test("start_while_busy", errs_before);
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial
    begin
        int i;
        n_tests           = 0;
        n_failed          = 0;
        n_checks          = 0;
        n_errors          = 0;
        rng_state         = 32'h023f3c0d;
        arst_n            = 1'b0;
        beg_fsm_cordic    = 1'b0;
        ack_cordic        = 1'b0;
        operation         = cordic_data_pkg::op_cos;
        shift_region_flag = cordic_data_pkg::region_direct;
        data_in           = '0;

        angles[0] = '0;
        angles[1] = to_fixed(PI / 6.0);
        angles[2] = to_fixed(PI / 4.0);
        angles[3] = to_fixed(-PI / 3.0);
        for (i = 4; i < N_ANGLES; i++)               // Uniform in -pi/2 to +pi/2.
        begin
            rng_state = next_random(rng_state);
            angles[i] = to_fixed((real'(rng_state) / 4294967296.0 * 2.0 - 1.0) * (PI / 2.0));
        end

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;

        reset_values();
        sine_direct();
        cosine_direct();
        region_flags();
        back_pressure();
        start_while_busy();

        n_errors = n_errors + DUT.u_props.fail_cnt;
        $display("Tests: %0d, with errors: %0d, checks: %0d, errors: %0d (assertions %0d)",
                 n_tests, n_failed, n_checks, n_errors, DUT.u_props.fail_cnt);
        if (n_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+include
source/cordic_data_pkg.sv
source/cordic_ctrl_pkg.sv
source/cordic_atan_rom.sv
source/cordic_fsm.sv
source/cordic_datapath.sv
source/cordic_output_stage.sv
source/cordic_top.sv
verification/cordic_props.sv
verification/cordic_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the CORDIC testbench with Verilator, then scan the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cordic_tb -f vlog.f \
    && ./obj_dir/Vcordic_tb +verilator+error+limit+1000 > sim.log 2>&1 \
    || { echo "Build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "Result: FAIL"; exit 1; }
grep -q "Simulation passed" sim.log || { echo "Result: no pass line in sim.log"; exit 1; }
echo "Result: PASS"
